// ==== all.f ====
csr_pkg.sv
csr_bus_if.sv
trap_if.sv
csr_access.sv
trap_sequencer.sv
csr_state.sv
csr_stage.sv
csr_stage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CSR stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module csr_stage_tb -o csr_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/csr_stage_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF "All tests passed!"; then
    exit 0
fi
exit 1

// ==== csr_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_stage_tb;
    import csr_pkg::*;

    logic       clk;
    logic       rst_n;
    counter_t   cycle;
    counter_t   time_now;
    counter_t   mtime;
    counter_t   mtimecmp;
    logic       flush;
    csr_cmd_t   csr_cmd;
    xlen_t      op1_data;
    xlen_t      imm_i;
    logic       irq_ready;
    xlen_t      if_pc;
    csr_cmd_t   csr_cmd_out;
    xlen_t      csr_rdata;
    xlen_t      trap_vector;
    logic       stall_may_irq;

    integer     seed;
    int         errors;
    int         checks;
    int         tests_run;
    int         tests_failed;
    int         test_start_errors;
    int         reset_edges;

    // Outputs captured one edge after a command
    xlen_t      rdata_seen;
    csr_cmd_t   cmd_seen;
    xlen_t      vec_seen;

    // Random operands
    xlen_t      val_a;
    xlen_t      val_b;
    xlen_t      val_c;
    xlen_t      pc_val;

    csr_stage #(
        .HART_ID (32'd5)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .cycle         (cycle),
        .time_now      (time_now),
        .mtime         (mtime),
        .mtimecmp      (mtimecmp),
        .flush         (flush),
        .csr_cmd       (csr_cmd),
        .op1_data      (op1_data),
        .imm_i         (imm_i),
        .irq_ready     (irq_ready),
        .if_pc         (if_pc),
        .csr_cmd_out   (csr_cmd_out),
        .csr_rdata     (csr_rdata),
        .trap_vector   (trap_vector),
        .stall_may_irq (stall_may_irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            reset_edges <= reset_edges + 1;
        end
    end

    // Outputs stay clear while reset is held
    reset_cmd_clear: assert property (@(posedge clk)
        (!rst_n && reset_edges >= 2) |-> (csr_cmd_out == CSR_X))
        else begin
            $display("FAILED at %0t: csr_cmd_out is %0d, expected %0d", $time,
                     $sampled(csr_cmd_out), CSR_X);
            errors = errors + 1;
        end

    reset_vec_clear: assert property (@(posedge clk)
        (!rst_n && reset_edges >= 2) |-> (trap_vector == '0))
        else begin
            $display("FAILED at %0t: trap_vector is %h, expected 00000000", $time,
                     $sampled(trap_vector));
            errors = errors + 1;
        end

    // mepc is word aligned, so an mret target is too
    mret_aligned: assert property (@(posedge clk)
        (csr_cmd_out == CSR_MRET) |-> (trap_vector[1:0] == 2'b00))
        else begin
            $display("FAILED at %0t: trap_vector[1:0] is %b, expected 00", $time,
                     $sampled(trap_vector[1:0]));
            errors = errors + 1;
        end

    task automatic check_val(input string name, input xlen_t got, input xlen_t exp);
        checks = checks + 1;
        assert (got == exp) else begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    // One command, then an idle cycle so its write lands
    task automatic run_cmd(input csr_cmd_t cmd, input csr_addr_t addr, input xlen_t op1,
                           input logic flush_in);
        csr_cmd  = cmd;
        imm_i    = {20'b0, addr};
        op1_data = op1;
        flush    = flush_in;
        @(posedge clk);
        #1;
        rdata_seen = csr_rdata;
        cmd_seen   = csr_cmd_out;
        vec_seen   = trap_vector;
        csr_cmd    = CSR_X;
        imm_i      = '0;
        op1_data   = '0;
        flush      = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic read_expect(input string name, input csr_addr_t addr, input xlen_t exp);
        run_cmd(CSR_X, addr, '0, 1'b0);
        check_val(name, rdata_seen, exp);
    endtask

    task automatic write_csr(input csr_addr_t addr, input xlen_t val);
        run_cmd(CSR_W, addr, val, 1'b0);
    endtask

    task automatic wait_pending(input int limit);
        int n;
        n = 0;
        while (!stall_may_irq && n < limit) begin
            @(posedge clk);
            #1;
            n = n + 1;
        end
        if (!stall_may_irq) begin
            $display("Timed out after %0d cycles waiting for stall_may_irq", limit);
            errors = errors + 1;
        end
    endtask

    // Single cycle of irq_ready, trap taken at that edge
    task automatic take_interrupt(input xlen_t pc);
        if_pc     = pc;
        irq_ready = 1'b1;
        @(posedge clk);
        #1;
        irq_ready = 1'b0;
        cmd_seen  = csr_cmd_out;
        vec_seen  = trap_vector;
    endtask

    task automatic end_test(input string name);
        tests_run = tests_run + 1;
        if (errors == test_start_errors) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        seed              = 32'h2a19_d839;
        errors            = 0;
        checks            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        test_start_errors = 0;
        reset_edges       = 0;
        rst_n             = 1'b0;
        flush             = 1'b0;
        csr_cmd           = CSR_X;
        op1_data          = '0;
        imm_i             = '0;
        irq_ready         = 1'b0;
        if_pc             = '0;
        cycle             = {$random(seed), $random(seed)};
        time_now          = '0;
        mtime             = '0;
        mtimecmp          = '1;

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset values and read-only identity registers
        check_val("csr_cmd_out", 32'(csr_cmd_out), 32'(CSR_X));
        check_val("trap_vector", trap_vector, '0);
        check_val("csr_rdata", csr_rdata, '0);
        check_val("stall_may_irq", {31'b0, stall_may_irq}, '0);
        read_expect("csr_rdata (misa)", CSR_ADDR_MISA, MISA_VALUE);
        read_expect("csr_rdata (mhartid)", CSR_ADDR_MHARTID, 32'd5);
        read_expect("csr_rdata (cycleh)", CSR_ADDR_CYCLEH, cycle[63:32]);
        end_test("reset and identity");

        // W, S and C each return the old value
        val_a = $random(seed);
        val_b = $random(seed);
        val_c = $random(seed);
        write_csr(CSR_ADDR_MSCRATCH, val_a);
        check_val("csr_rdata (mscratch W)", rdata_seen, '0);
        run_cmd(CSR_S, CSR_ADDR_MSCRATCH, val_b, 1'b0);
        check_val("csr_rdata (mscratch S)", rdata_seen, val_a);
        run_cmd(CSR_C, CSR_ADDR_MSCRATCH, val_c, 1'b0);
        check_val("csr_rdata (mscratch C)", rdata_seen, val_a | val_b);
        read_expect("csr_rdata (mscratch)", CSR_ADDR_MSCRATCH, (val_a | val_b) & ~val_c);
        val_a = $random(seed);
        write_csr(CSR_ADDR_MISA, val_a);
        check_val("csr_rdata (misa W)", rdata_seen, MISA_VALUE);
        read_expect("csr_rdata (misa)", CSR_ADDR_MISA, MISA_VALUE);
        end_test("read-modify-write");

        // Vectored mtvec, ecall still goes to the base
        write_csr(CSR_ADDR_MTVEC, 32'h8000_0101);
        run_cmd(CSR_ECALL, 12'h000, '0, 1'b0);
        check_val("csr_cmd_out", 32'(cmd_seen), 32'(CSR_ECALL));
        check_val("trap_vector", vec_seen, 32'h8000_0100);
        read_expect("csr_rdata (mcause)", CSR_ADDR_MCAUSE, 32'd11);
        val_a = $random(seed);
        write_csr(CSR_ADDR_MEPC, val_a);
        // MPP = S, so mret drops to S-mode
        write_csr(CSR_ADDR_MSTATUS, 32'h0000_0800);
        run_cmd(CSR_MRET, 12'h000, '0, 1'b0);
        check_val("csr_cmd_out", 32'(cmd_seen), 32'(CSR_MRET));
        check_val("trap_vector", vec_seen, {val_a[31:2], 2'b00});
        read_expect("csr_rdata (mscratch from S)", CSR_ADDR_MSCRATCH, '0);
        run_cmd(CSR_ECALL, 12'h000, '0, 1'b0);
        check_val("trap_vector", vec_seen, 32'h8000_0100);
        read_expect("csr_rdata (mcause)", CSR_ADDR_MCAUSE, 32'd9);
        end_test("ecall and returns");

        // Timer interrupt, back in M-mode
        write_csr(CSR_ADDR_MTVEC, 32'h0000_2001);
        write_csr(CSR_ADDR_MIE, 32'h0000_0080);
        write_csr(CSR_ADDR_MSTATUS, 32'h0000_1808);
        mtime    = 64'h0000_0001_0000_0000;
        mtimecmp = 64'h0000_0001_0000_0000;
        wait_pending(20);
        pc_val = $random(seed);
        take_interrupt(pc_val);
        mtime = '0;
        check_val("csr_cmd_out", 32'(cmd_seen), 32'(CSR_ECALL));
        check_val("trap_vector", vec_seen, 32'h0000_2000 + 32'd28);
        read_expect("csr_rdata (mcause)", CSR_ADDR_MCAUSE, 32'h8000_0007);
        read_expect("csr_rdata (mepc)", CSR_ADDR_MEPC, {pc_val[31:2], 2'b00});
        // MIE cleared, old MIE stacked in MPIE, MPP = M
        read_expect("csr_rdata (mstatus)", CSR_ADDR_MSTATUS, 32'h0000_1880);
        check_val("stall_may_irq", {31'b0, stall_may_irq}, '0);
        end_test("timer interrupt");

        // SSI delegated to S-mode
        write_csr(CSR_ADDR_MIDELEG, 32'h0000_0002);
        write_csr(CSR_ADDR_STVEC, 32'h0000_3001);
        write_csr(CSR_ADDR_MIP, 32'h0000_0002);
        wait_pending(20);
        pc_val = $random(seed);
        take_interrupt(pc_val);
        check_val("csr_cmd_out", 32'(cmd_seen), 32'(CSR_ECALL));
        check_val("trap_vector", vec_seen, 32'h0000_3000 + 32'd4);
        read_expect("csr_rdata (scause)", CSR_ADDR_SCAUSE, 32'h8000_0001);
        read_expect("csr_rdata (sepc)", CSR_ADDR_SEPC, pc_val);
        // Clear SSIP through the S view
        write_csr(CSR_ADDR_SIP, '0);
        check_val("stall_may_irq", {31'b0, stall_may_irq}, '0);
        end_test("delegated interrupt");

        // Flushed write is dropped
        val_a = $random(seed);
        val_b = $random(seed);
        write_csr(CSR_ADDR_SSCRATCH, val_a);
        run_cmd(CSR_W, CSR_ADDR_SSCRATCH, val_b, 1'b1);
        check_val("csr_rdata (flushed)", rdata_seen, '0);
        check_val("csr_cmd_out", 32'(cmd_seen), 32'(CSR_X));
        read_expect("csr_rdata (sscratch)", CSR_ADDR_SSCRATCH, val_a);
        end_test("flush");

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== csr_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_stage #(
    parameter csr_pkg::xlen_t HART_ID = 32'd0
) (
    input  wire                 clk,
    input  wire                 rst_n,

    // Counters from the timer block
    input  csr_pkg::counter_t   cycle,
    input  csr_pkg::counter_t   time_now,
    input  csr_pkg::counter_t   mtime,
    input  csr_pkg::counter_t   mtimecmp,

    // Command from decode, flush on a taken branch
    input  wire                 flush,
    input  csr_pkg::csr_cmd_t   csr_cmd,
    input  csr_pkg::xlen_t      op1_data,
    input  csr_pkg::xlen_t      imm_i,

    // High when the rest of the pipeline is empty
    input  wire                 irq_ready,
    input  csr_pkg::xlen_t      if_pc,

    output csr_pkg::csr_cmd_t   csr_cmd_out,
    output csr_pkg::xlen_t      csr_rdata,
    output csr_pkg::xlen_t      trap_vector,
    output wire                 stall_may_irq
);

    csr_bus_if bus0 ();
    trap_if    trap0 ();

    csr_access access0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .csr_cmd   (csr_cmd),
        .op1_data  (op1_data),
        .imm_i     (imm_i),
        .csr_rdata (csr_rdata),
        .bus       (bus0.access)
    );

    trap_sequencer seq0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .irq_ready     (irq_ready),
        .csr_cmd       (csr_cmd),
        .if_pc         (if_pc),
        .csr_cmd_out   (csr_cmd_out),
        .trap_vector   (trap_vector),
        .stall_may_irq (stall_may_irq),
        .trap          (trap0.seq)
    );

    csr_state #(
        .HART_ID (HART_ID)
    ) state0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .cycle    (cycle),
        .time_now (time_now),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .bus      (bus0.state),
        .trap     (trap0.state)
    );

endmodule

`default_nettype wire

// ==== csr_state.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_state #(
    parameter csr_pkg::xlen_t HART_ID = 32'd0
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  csr_pkg::counter_t   cycle,
    input  csr_pkg::counter_t   time_now,
    input  csr_pkg::counter_t   mtime,
    input  csr_pkg::counter_t   mtimecmp,
    csr_bus_if.state            bus,
    trap_if.state               trap
);
    import csr_pkg::*;

    priv_t mode;

    // mstatus fields kept
    logic  st_mie;
    logic  st_sie;
    logic  st_mpie;
    logic  st_spie;
    priv_t st_mpp;
    logic  st_spp;
    logic  st_mprv;

    // Enables
    logic  mie_meie;
    logic  mie_seie;
    logic  mie_mtie;
    logic  mie_stie;
    logic  mie_msie;
    logic  mie_ssie;

    // Pending, MEIP and MSIP have no source
    logic  mip_seip;
    logic  mip_mtip;
    logic  mip_stip;
    logic  mip_ssip;

    xlen_t mideleg;
    xlen_t mtvec;
    xlen_t stvec;
    xlen_t mepc;
    xlen_t sepc;
    xlen_t mcause;
    xlen_t scause;
    xlen_t mscratch;
    xlen_t sscratch;

    xlen_t mstatus_v;
    xlen_t sstatus_v;
    xlen_t mie_v;
    xlen_t mip_v;
    xlen_t w;

    assign mstatus_v = {14'b0, st_mprv, 4'b0, st_mpp, 2'b0, st_spp, st_mpie, 1'b0,
                        st_spie, 1'b0, st_mie, 1'b0, st_sie, 1'b0};
    assign sstatus_v = {23'b0, st_spp, 2'b0, st_spie, 3'b0, st_sie, 1'b0};
    assign mie_v = {20'b0, mie_meie, 1'b0, mie_seie, 1'b0, mie_mtie, 1'b0,
                    mie_stie, 1'b0, mie_msie, 1'b0, mie_ssie, 1'b0};
    assign mip_v = {20'b0, 1'b0, 1'b0, mip_seip, 1'b0, mip_mtip, 1'b0,
                    mip_stip, 1'b0, 1'b0, 1'b0, mip_ssip, 1'b0};
    assign w = bus.wr_data;

    assign bus.cur_mode = mode;
    assign trap.mode    = mode;
    assign trap.mpp     = st_mpp;
    assign trap.mepc    = mepc;
    assign trap.sepc    = sepc;
    assign trap.mtvec   = mtvec;
    assign trap.stvec   = stvec;
    assign trap.mideleg = mideleg;
    assign trap.pend    = {mip_v[11], mip_v[3], mip_mtip, mip_seip, mip_ssip, mip_stip};

    // Read mux, unknown addresses read zero
    always_comb begin
        case (bus.rd_addr)
            CSR_ADDR_CYCLE:    bus.rd_data = cycle[31:0];
            CSR_ADDR_TIME:     bus.rd_data = time_now[31:0];
            CSR_ADDR_CYCLEH:   bus.rd_data = cycle[63:32];
            CSR_ADDR_TIMEH:    bus.rd_data = time_now[63:32];
            CSR_ADDR_MHARTID:  bus.rd_data = HART_ID;
            CSR_ADDR_MSTATUS:  bus.rd_data = mstatus_v;
            CSR_ADDR_MISA:     bus.rd_data = MISA_VALUE;
            CSR_ADDR_MIDELEG:  bus.rd_data = mideleg;
            CSR_ADDR_MIE:      bus.rd_data = mie_v;
            CSR_ADDR_MTVEC:    bus.rd_data = mtvec;
            CSR_ADDR_MSCRATCH: bus.rd_data = mscratch;
            CSR_ADDR_MEPC:     bus.rd_data = mepc;
            CSR_ADDR_MCAUSE:   bus.rd_data = mcause;
            CSR_ADDR_MIP:      bus.rd_data = mip_v;
            CSR_ADDR_SSTATUS:  bus.rd_data = sstatus_v;
            // S views keep SEI, STI and SSI bits only
            CSR_ADDR_SIE:      bus.rd_data = mie_v & 32'h0000_0222;
            CSR_ADDR_STVEC:    bus.rd_data = stvec;
            CSR_ADDR_SSCRATCH: bus.rd_data = sscratch;
            CSR_ADDR_SEPC:     bus.rd_data = sepc;
            CSR_ADDR_SCAUSE:   bus.rd_data = scause;
            CSR_ADDR_SIP:      bus.rd_data = mip_v & 32'h0000_0222;
            default:           bus.rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode     <= PRIV_M;
            st_mie   <= 1'b0;
            st_sie   <= 1'b0;
            st_mpie  <= 1'b0;
            st_spie  <= 1'b0;
            st_mpp   <= PRIV_M;
            st_spp   <= 1'b0;
            st_mprv  <= 1'b0;
            mie_meie <= 1'b0;
            mie_seie <= 1'b0;
            mie_mtie <= 1'b0;
            mie_stie <= 1'b0;
            mie_msie <= 1'b0;
            mie_ssie <= 1'b0;
            mip_seip <= 1'b0;
            mip_mtip <= 1'b0;
            mip_stip <= 1'b0;
            mip_ssip <= 1'b0;
            mideleg  <= '0;
            mtvec    <= '0;
            stvec    <= '0;
            mepc     <= '0;
            sepc     <= '0;
            mcause   <= '0;
            scause   <= '0;
            mscratch <= '0;
            sscratch <= '0;
        end else begin
            // Timer pending held while an interrupt is being entered
            if (!trap.take_irq) begin
                mip_mtip <= st_mie && mie_mtie && (mtime >= mtimecmp);
            end

            // Trap entry and return first
            if (trap.take_irq && !trap.to_s) begin
                mode    <= PRIV_M;
                mcause  <= trap.cause;
                mepc    <= {trap.epc[31:2], 2'b00};
                st_mpp  <= mode;
                st_mpie <= st_mie;
                st_mie  <= 1'b0;
            end else if (trap.take_irq) begin
                mode    <= PRIV_S;
                scause  <= trap.cause;
                sepc    <= trap.epc;
                st_spp  <= mode[0];
                st_spie <= st_sie;
                st_sie  <= 1'b0;
            end else if (trap.ecall) begin
                // One level up, U goes to S
                mcause  <= trap.cause;
                mode    <= (mode == PRIV_U) ? PRIV_S : PRIV_M;
            end else if (trap.mret) begin
                mode    <= st_mpp;
                st_mie  <= st_mpie;
                st_mpie <= 1'b1;
                st_mpp  <= PRIV_U;
                if (st_mpp != PRIV_M) begin
                    st_mprv <= 1'b0;
                end
            end else if (trap.sret) begin
                mode    <= st_spp ? PRIV_S : PRIV_U;
                st_sie  <= st_spie;
                st_spie <= 1'b1;
                st_spp  <= 1'b0;
                st_mprv <= 1'b0;
            end

            // Software write wins on the same field
            if (bus.wr_en) begin
                case (bus.wr_addr)
                    CSR_ADDR_MSTATUS: begin
                        st_mprv <= w[17];
                        st_mpp  <= priv_t'(w[12:11]);
                        st_spp  <= w[8];
                        st_mpie <= w[7];
                        st_spie <= w[5];
                        st_mie  <= w[3];
                        st_sie  <= w[1];
                    end
                    CSR_ADDR_SSTATUS: begin
                        st_spp  <= w[8];
                        st_spie <= w[5];
                        st_sie  <= w[1];
                    end
                    CSR_ADDR_MIE: begin
                        mie_meie <= w[11];
                        mie_seie <= w[9];
                        mie_mtie <= w[7];
                        mie_stie <= w[5];
                        mie_msie <= w[3];
                        mie_ssie <= w[1];
                    end
                    CSR_ADDR_SIE: begin
                        mie_seie <= w[9];
                        mie_stie <= w[5];
                        mie_ssie <= w[1];
                    end
                    // MTIP stays under hardware control
                    CSR_ADDR_MIP, CSR_ADDR_SIP: begin
                        mip_seip <= w[9];
                        mip_stip <= w[5];
                        mip_ssip <= w[1];
                    end
                    // Only S-level interrupts can be delegated
                    CSR_ADDR_MIDELEG:  mideleg  <= w & 32'h0000_0222;
                    CSR_ADDR_MTVEC:    mtvec    <= w;
                    CSR_ADDR_STVEC:    stvec    <= w;
                    CSR_ADDR_MEPC:     mepc     <= {w[31:2], 2'b00};
                    CSR_ADDR_SEPC:     sepc     <= w;
                    CSR_ADDR_MCAUSE:   mcause   <= w;
                    CSR_ADDR_SCAUSE:   scause   <= w;
                    CSR_ADDR_MSCRATCH: mscratch <= w;
                    CSR_ADDR_SSCRATCH: sscratch <= w;
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== trap_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_sequencer (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 flush,
    input  wire                 irq_ready,
    input  csr_pkg::csr_cmd_t   csr_cmd,
    input  csr_pkg::xlen_t      if_pc,
    output csr_pkg::csr_cmd_t   csr_cmd_out,
    output csr_pkg::xlen_t      trap_vector,
    output wire                 stall_may_irq,
    trap_if.seq                 trap
);
    import csr_pkg::*;

    csr_cmd_t cmd;
    logic     irq_go;
    xlen_t    irq_cause;
    xlen_t    ecall_cause;
    xlen_t    m_target;
    xlen_t    s_target;

    // Base with mode bits cleared, cause offset only for vectored interrupts
    function automatic xlen_t vec_target(input xlen_t tvec, input xlen_t cause,
                                         input logic is_irq);
        xlen_t base;
        base = {tvec[31:2], 2'b00};
        if (is_irq && tvec[1:0] == 2'b01) begin
            vec_target = base + {cause[29:0], 2'b00};
        end else begin
            vec_target = base;
        end
    endfunction

    assign cmd = flush ? CSR_X : csr_cmd;

    // Any pending bit asks upstream to drain
    assign stall_may_irq = |trap.pend;
    assign irq_go        = stall_may_irq && irq_ready;

    // Fixed priority, MEI highest
    always_comb begin
        if (trap.pend[5]) irq_cause = CAUSE_IRQ_MEI;
        else if (trap.pend[4]) irq_cause = CAUSE_IRQ_MSI;
        else if (trap.pend[3]) irq_cause = CAUSE_IRQ_MTI;
        else if (trap.pend[2]) irq_cause = CAUSE_IRQ_SEI;
        else if (trap.pend[1]) irq_cause = CAUSE_IRQ_SSI;
        else irq_cause = CAUSE_IRQ_STI;
    end

    always_comb begin
        case (trap.mode)
            PRIV_U:  ecall_cause = CAUSE_ECALL_U;
            PRIV_S:  ecall_cause = CAUSE_ECALL_S;
            default: ecall_cause = CAUSE_ECALL_M;
        endcase
    end

    assign m_target = vec_target(trap.mtvec, irq_cause, irq_go);
    assign s_target = vec_target(trap.stvec, irq_cause, irq_go);

    // Set mideleg bit sends the interrupt to S-mode
    assign trap.to_s     = trap.mideleg[irq_cause[4:0]];
    assign trap.take_irq = irq_go;
    assign trap.cause    = irq_go ? irq_cause : ecall_cause;
    assign trap.epc      = if_pc;

    // Interrupt wins, the command's own trap effect is dropped
    assign trap.ecall = !irq_go && cmd == CSR_ECALL;
    assign trap.mret  = !irq_go && cmd == CSR_MRET;
    assign trap.sret  = !irq_go && cmd == CSR_SRET;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_cmd_out <= CSR_X;
            trap_vector <= '0;
        end else if (irq_go) begin
            // Reported as ecall so the pipeline redirects
            csr_cmd_out <= CSR_ECALL;
            trap_vector <= trap.to_s ? s_target : m_target;
        end else begin
            csr_cmd_out <= cmd;
            case (cmd)
                CSR_ECALL: trap_vector <= (trap.mode == PRIV_U) ? s_target : m_target;
                CSR_MRET:  trap_vector <= trap.mepc;
                CSR_SRET:  trap_vector <= trap.sepc;
                default:   trap_vector <= trap_vector;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== csr_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_access (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 flush,
    input  csr_pkg::csr_cmd_t   csr_cmd,
    input  csr_pkg::xlen_t      op1_data,
    input  csr_pkg::xlen_t      imm_i,
    output csr_pkg::xlen_t      csr_rdata,
    csr_bus_if.access           bus
);
    import csr_pkg::*;

    csr_cmd_t  cmd;
    csr_addr_t addr;
    logic      can_read;
    logic      can_write;

    // Second stage, command held for the write
    csr_cmd_t  cmd_q;
    csr_addr_t addr_q;
    xlen_t     op1_q;
    logic      wr_ok_q;

    // Flushed slot becomes a no-op on an address nobody answers
    assign cmd  = flush ? CSR_X : csr_cmd;
    assign addr = flush ? 12'hfff : imm_i[11:0];

    // Bits 9:8 give the lowest privilege allowed
    assign can_read  = addr[9:8] <= bus.cur_mode;
    // Bits 11:10 of 11 mark a read-only register
    assign can_write = can_read && (addr[11:10] != 2'b11);

    assign bus.rd_addr = addr;

    // Old value, zero when access is denied
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_rdata <= '0;
        end else begin
            csr_rdata <= can_read ? bus.rd_data : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_q   <= CSR_X;
            wr_ok_q <= 1'b0;
        end else begin
            cmd_q   <= cmd;
            wr_ok_q <= can_write;
        end
    end

    // Payload, qualified by cmd_q
    always_ff @(posedge clk) begin
        addr_q <= addr;
        op1_q  <= op1_data;
    end

    // Read-modify-write from the registered old value
    always_comb begin
        bus.wr_en   = 1'b0;
        bus.wr_data = '0;
        case (cmd_q)
            CSR_W: begin
                bus.wr_en   = wr_ok_q;
                bus.wr_data = op1_q;
            end
            CSR_S: begin
                bus.wr_en   = wr_ok_q;
                bus.wr_data = csr_rdata | op1_q;
            end
            CSR_C: begin
                bus.wr_en   = wr_ok_q;
                bus.wr_data = csr_rdata & ~op1_q;
            end
            default: begin
                bus.wr_en   = 1'b0;
            end
        endcase
    end

    assign bus.wr_addr = addr_q;

endmodule

`default_nettype wire

// ==== trap_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface trap_if;
    import csr_pkg::*;

    // Trap entry, one cycle strobe
    logic        take_irq;
    logic        to_s;
    xlen_t       cause;
    xlen_t       epc;
    // Exception and return strobes
    logic        ecall;
    logic        mret;
    logic        sret;

    // State seen by the sequencer
    priv_t       mode;
    priv_t       mpp;
    xlen_t       mepc;
    xlen_t       sepc;
    xlen_t       mtvec;
    xlen_t       stvec;
    // Priority order MEI, MSI, MTI, SEI, SSI, STI from bit 5 down
    logic [5:0]  pend;
    xlen_t       mideleg;

    modport seq (
        output take_irq, to_s, cause, epc, ecall, mret, sret,
        input  mode, mpp, mepc, sepc, mtvec, stvec, pend, mideleg
    );

    modport state (
        input  take_irq, to_s, cause, epc, ecall, mret, sret,
        output mode, mpp, mepc, sepc, mtvec, stvec, pend, mideleg
    );

endinterface

`default_nettype wire

// ==== csr_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface csr_bus_if;
    import csr_pkg::*;

    // Read port, combinational
    csr_addr_t rd_addr;
    xlen_t     rd_data;
    // Write port, lands on the next edge
    logic      wr_en;
    csr_addr_t wr_addr;
    xlen_t     wr_data;
    // Current privilege for the access check
    priv_t     cur_mode;

    modport access (
        output rd_addr, wr_en, wr_addr, wr_data,
        input  rd_data, cur_mode
    );

    modport state (
        input  rd_addr, wr_en, wr_addr, wr_data,
        output rd_data, cur_mode
    );

endinterface

`default_nettype wire

// ==== csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // Machine word, also used for addresses and causes
    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;
    // Cycle, time, mtime and mtimecmp
    typedef logic [63:0] counter_t;

    // Commands from the decode stage
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5,
        CSR_SRET  = 3'd6
    } csr_cmd_t;

    // Privilege levels, H-mode not supported
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

    // Counters, read only
    localparam csr_addr_t CSR_ADDR_CYCLE    = 12'hc00;
    localparam csr_addr_t CSR_ADDR_TIME     = 12'hc01;
    localparam csr_addr_t CSR_ADDR_CYCLEH   = 12'hc80;
    localparam csr_addr_t CSR_ADDR_TIMEH    = 12'hc81;
    localparam csr_addr_t CSR_ADDR_MHARTID  = 12'hf14;

    // Machine level
    localparam csr_addr_t CSR_ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_ADDR_MISA     = 12'h301;
    localparam csr_addr_t CSR_ADDR_MIDELEG  = 12'h303;
    localparam csr_addr_t CSR_ADDR_MIE      = 12'h304;
    localparam csr_addr_t CSR_ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_ADDR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_ADDR_MIP      = 12'h344;

    // Supervisor level, status, enable and pending are views of the M registers
    localparam csr_addr_t CSR_ADDR_SSTATUS  = 12'h100;
    localparam csr_addr_t CSR_ADDR_SIE      = 12'h104;
    localparam csr_addr_t CSR_ADDR_STVEC    = 12'h105;
    localparam csr_addr_t CSR_ADDR_SSCRATCH = 12'h140;
    localparam csr_addr_t CSR_ADDR_SEPC     = 12'h141;
    localparam csr_addr_t CSR_ADDR_SCAUSE   = 12'h142;
    localparam csr_addr_t CSR_ADDR_SIP      = 12'h144;

    // Synchronous exception causes
    localparam xlen_t CAUSE_ECALL_U = 32'd8;
    localparam xlen_t CAUSE_ECALL_S = 32'd9;
    localparam xlen_t CAUSE_ECALL_M = 32'd11;

    // Interrupt causes, top bit marks an interrupt
    localparam xlen_t CAUSE_IRQ_SSI = 32'h8000_0001;
    localparam xlen_t CAUSE_IRQ_MSI = 32'h8000_0003;
    localparam xlen_t CAUSE_IRQ_STI = 32'h8000_0005;
    localparam xlen_t CAUSE_IRQ_MTI = 32'h8000_0007;
    localparam xlen_t CAUSE_IRQ_SEI = 32'h8000_0009;
    localparam xlen_t CAUSE_IRQ_MEI = 32'h8000_000b;

    // MXL = 32 bit, extensions A, I and M
    localparam xlen_t MISA_VALUE = 32'h4000_1101;

endpackage

`default_nettype wire
